/* sim/tb_tcp_mem_glue.sv */
/*
  random traffic on both tx channel paths, checked against a queue model
  fixed seed, ready inputs high about 3 cycles in 4
  run ends when all streams drain, or at the cycle limit
*/
`timescale 1ns/1ps

module tb_tcp_mem_glue;

  import tcp_mem_pkg::*;

  localparam int NET_WIDTH    = 64;
  localparam int MEM_WIDTH    = 512;
  localparam int RATIO        = MEM_WIDTH / NET_WIDTH;
  localparam int NK           = NET_WIDTH / 8;
  localparam int MK           = MEM_WIDTH / 8;
  localparam int N_CMD        = 200;   // commands per direction
  localparam int N_PKT        = 100;   // packets per direction
  localparam int MAX_RD_BEATS = 4;     // wide beats per read packet
  localparam int MAX_WR_BEATS = 12;    // narrow beats per write packet
  // four cycles per beat for random valid and ready gaps, then doubled
  localparam int MAX_CYCLES   = 2 * 4 * (N_CMD + N_PKT * MAX_RD_BEATS * RATIO
                                         + N_PKT * MAX_WR_BEATS);

  logic                 net_clk = 1'b0;
  logic                 net_aresetn;
  logic                 eng_read_cmd_valid, eng_read_cmd_ready;
  hls_mem_cmd_t         eng_read_cmd_data;
  logic                 mem_read_cmd_valid, mem_read_cmd_ready;
  mem_addr_t            mem_read_cmd_address;
  mem_len_t             mem_read_cmd_length;
  logic                 mem_read_data_valid, mem_read_data_ready, mem_read_data_last;
  logic [MEM_WIDTH-1:0] mem_read_data_data;
  logic [MK-1:0]        mem_read_data_keep;
  logic                 eng_read_data_valid, eng_read_data_ready, eng_read_data_last;
  logic [NET_WIDTH-1:0] eng_read_data_data;
  logic [NK-1:0]        eng_read_data_keep;
  logic                 eng_write_cmd_valid, eng_write_cmd_ready;
  hls_mem_cmd_t         eng_write_cmd_data;
  logic                 mem_write_cmd_valid, mem_write_cmd_ready;
  mem_addr_t            mem_write_cmd_address;
  mem_len_t             mem_write_cmd_length;
  logic                 eng_write_data_valid, eng_write_data_ready, eng_write_data_last;
  logic [NET_WIDTH-1:0] eng_write_data_data;
  logic [NK-1:0]        eng_write_data_keep;
  logic                 mem_write_data_valid, mem_write_data_ready, mem_write_data_last;
  logic [MEM_WIDTH-1:0] mem_write_data_data;
  logic [MK-1:0]        mem_write_data_keep;
  activity_cnt_t        read_cmd_count, read_pkt_count, write_cmd_count, write_pkt_count;
  activity_cnt_t        outstanding_reads;

  integer seed = 32'h4b382844;
  int     errors = 0;
  int     checks = 0;
  int     cycle_cnt = 0;
  bit     run = 1'b0;                  // stimulus enable
  int     rd_cmd_left, wr_cmd_left, rd_pkt_left, wr_pkt_left;
  int     rd_beats_left, wr_beats_left; // beats left in current packet
  bit     rd_cmd_go, wr_cmd_go, rd_dat_go, wr_dat_go;  // source transfers at last edge
  int     rd_cmd_n, rd_pkt_n, wr_cmd_n, wr_pkt_n;      // model event totals
  logic [95:0]           rd_cmd_q[$];  // {address, length}
  logic [95:0]           wr_cmd_q[$];
  logic [NET_WIDTH+NK:0] rd_dat_q[$];  // {last, keep, data}
  logic [MEM_WIDTH+MK:0] wr_dat_q[$];
  logic [MEM_WIDTH-1:0]  acc_data;     // write packing model
  logic [MK-1:0]         acc_keep;
  int                    acc_fill = 0;

  tcp_mem_glue #(.NET_WIDTH(NET_WIDTH), .MEM_WIDTH(MEM_WIDTH)) i_dut (.*);

  always #2 net_clk = ~net_clk;         // 4 ns period

  always @(posedge net_clk) cycle_cnt <= cycle_cnt + 1;

  task automatic check_value(input string name, input logic [MEM_WIDTH-1:0] got,
                             input logic [MEM_WIDTH-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_expected(input string name, input int pending);
    checks++;
    assert (pending > 0) else begin
      errors++;
      $display("%0t %s moved a beat that the model did not expect", $time, name);
    end
  endtask

  task automatic check_idle();
    check_value("eng_read_data_valid", eng_read_data_valid, 0);
    check_value("mem_write_data_valid", mem_write_data_valid, 0);
    check_value("read_cmd_count", read_cmd_count, 0);
    check_value("read_pkt_count", read_pkt_count, 0);
    check_value("write_cmd_count", write_cmd_count, 0);
    check_value("write_pkt_count", write_pkt_count, 0);
    check_value("outstanding_reads", outstanding_reads, 0);
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  task automatic new_cmd(output hls_mem_cmd_t cmd);
    cmd[71:64] = $random(seed);
    cmd[63:32] = $random(seed);
    cmd[31:0]  = $random(seed);
    if (cmd[22:0] == '0)
      cmd[0] = 1'b1;                    // zero length is illegal
  endtask

  task automatic new_wide_beat(input logic last);
    int used;
    int r;
    used = 1 + ($unsigned($random(seed)) % RATIO);   // slices in use
    for (int i = 0; i < MEM_WIDTH / 32; i++)
      mem_read_data_data[i*32 +: 32] = $random(seed);
    for (int b = 0; b < MK; b++) begin
      r = $random(seed);
      mem_read_data_keep[b] = (b < used * NK) && (r[2:0] != 0);  // a few holes
    end
    if (mem_read_data_keep == '0)
      mem_read_data_keep[0] = 1'b1;
    mem_read_data_last = last;
  endtask

  task automatic new_narrow_beat(input logic last);
    eng_write_data_data = {$random(seed), $random(seed)};
    eng_write_data_keep = NK'($random(seed));        // any keep, even zero
    eng_write_data_last = last;
  endtask

  function automatic bit all_done();
    return rd_cmd_left == 0 && wr_cmd_left == 0 && rd_pkt_left == 0 && wr_pkt_left == 0
        && rd_beats_left == 0 && wr_beats_left == 0
        && !eng_read_cmd_valid && !eng_write_cmd_valid
        && !mem_read_data_valid && !eng_write_data_valid
        && rd_cmd_q.size() == 0 && wr_cmd_q.size() == 0
        && rd_dat_q.size() == 0 && wr_dat_q.size() == 0;
  endfunction

  // sources hold until taken, sinks throttle at random
  always @(negedge net_clk) begin
    if (run) begin
      mem_read_cmd_ready   = ($random(seed) & 3) != 0;
      eng_read_data_ready  = ($random(seed) & 3) != 0;
      mem_write_cmd_ready  = ($random(seed) & 3) != 0;
      mem_write_data_ready = ($random(seed) & 3) != 0;
      if (!eng_read_cmd_valid || rd_cmd_go) begin
        eng_read_cmd_valid = 1'b0;
        if (rd_cmd_left > 0 && ($random(seed) & 3) != 0) begin
          new_cmd(eng_read_cmd_data);
          eng_read_cmd_valid = 1'b1;
          rd_cmd_left--;
        end
      end
      if (!eng_write_cmd_valid || wr_cmd_go) begin
        eng_write_cmd_valid = 1'b0;
        if (wr_cmd_left > 0 && ($random(seed) & 3) != 0) begin
          new_cmd(eng_write_cmd_data);
          eng_write_cmd_valid = 1'b1;
          wr_cmd_left--;
        end
      end
      if (!mem_read_data_valid || rd_dat_go) begin
        mem_read_data_valid = 1'b0;
        if ((rd_beats_left > 0 || rd_pkt_left > 0) && ($random(seed) & 3) != 0) begin
          if (rd_beats_left == 0) begin
            rd_beats_left = 1 + ($unsigned($random(seed)) % MAX_RD_BEATS);  // new packet
            rd_pkt_left--;
          end
          new_wide_beat(rd_beats_left == 1);
          mem_read_data_valid = 1'b1;
          rd_beats_left--;
        end
      end
      if (!eng_write_data_valid || wr_dat_go) begin
        eng_write_data_valid = 1'b0;
        if ((wr_beats_left > 0 || wr_pkt_left > 0) && ($random(seed) & 3) != 0) begin
          if (wr_beats_left == 0) begin
            wr_beats_left = 1 + ($unsigned($random(seed)) % MAX_WR_BEATS);
            wr_pkt_left--;
          end
          new_narrow_beat(wr_beats_left == 1);
          eng_write_data_valid = 1'b1;
          wr_beats_left--;
        end
      end
    end
  end

  // reference model, fed by source transfers and checked at sink transfers
  always @(posedge net_clk) begin : model
    logic [95:0]           c;
    logic [NET_WIDTH+NK:0] n;
    logic [MEM_WIDTH+MK:0] w;
    int                    top;
    rd_cmd_go = eng_read_cmd_valid && eng_read_cmd_ready;
    wr_cmd_go = eng_write_cmd_valid && eng_write_cmd_ready;
    rd_dat_go = mem_read_data_valid && mem_read_data_ready;
    wr_dat_go = eng_write_data_valid && eng_write_data_ready;
    if (net_aresetn) begin
      if (rd_cmd_go) begin              // address 63..32, length 22..0
        rd_cmd_q.push_back({32'h0, eng_read_cmd_data[63:32], 9'h0, eng_read_cmd_data[22:0]});
        rd_cmd_n++;
      end
      if (wr_cmd_go) begin
        wr_cmd_q.push_back({32'h0, eng_write_cmd_data[63:32], 9'h0, eng_write_cmd_data[22:0]});
        wr_cmd_n++;
      end
      if (mem_read_cmd_valid && mem_read_cmd_ready) begin
        check_expected("mem_read_cmd", rd_cmd_q.size());
        if (rd_cmd_q.size() > 0) begin
          c = rd_cmd_q.pop_front();
          check_value("mem_read_cmd_address", mem_read_cmd_address, c[95:32]);
          check_value("mem_read_cmd_length", mem_read_cmd_length, c[31:0]);
        end
      end
      if (mem_write_cmd_valid && mem_write_cmd_ready) begin
        check_expected("mem_write_cmd", wr_cmd_q.size());
        if (wr_cmd_q.size() > 0) begin
          c = wr_cmd_q.pop_front();
          check_value("mem_write_cmd_address", mem_write_cmd_address, c[95:32]);
          check_value("mem_write_cmd_length", mem_write_cmd_length, c[31:0]);
        end
      end
      if (rd_dat_go) begin
        top = 0;
        for (int i = 0; i < RATIO; i++)
          if (mem_read_data_keep[i*NK +: NK] != '0)
            top = i;                    // highest slice with keep
        for (int i = 0; i <= top; i++)
          rd_dat_q.push_back({mem_read_data_last && (i == top),
                              mem_read_data_keep[i*NK +: NK],
                              mem_read_data_data[i*NET_WIDTH +: NET_WIDTH]});
        if (mem_read_data_last)
          rd_pkt_n++;
      end
      if (eng_read_data_valid && eng_read_data_ready) begin
        check_expected("eng_read_data", rd_dat_q.size());
        if (rd_dat_q.size() > 0) begin
          n = rd_dat_q.pop_front();
          check_value("eng_read_data_data", eng_read_data_data, n[NET_WIDTH-1:0]);
          check_value("eng_read_data_keep", eng_read_data_keep, n[NET_WIDTH +: NK]);
          check_value("eng_read_data_last", eng_read_data_last, n[NET_WIDTH+NK]);
        end
      end
      if (wr_dat_go) begin
        if (acc_fill == 0) begin
          acc_data = '0;                // unfilled slices stay zero
          acc_keep = '0;
        end
        acc_data[acc_fill*NET_WIDTH +: NET_WIDTH] = eng_write_data_data;
        acc_keep[acc_fill*NK +: NK] = eng_write_data_keep;
        acc_fill++;
        if (eng_write_data_last || acc_fill == RATIO) begin
          wr_dat_q.push_back({eng_write_data_last, acc_keep, acc_data});
          acc_fill = 0;
        end
        if (eng_write_data_last)
          wr_pkt_n++;
      end
      if (mem_write_data_valid && mem_write_data_ready) begin
        check_expected("mem_write_data", wr_dat_q.size());
        if (wr_dat_q.size() > 0) begin
          w = wr_dat_q.pop_front();
          check_value("mem_write_data_data", mem_write_data_data, w[MEM_WIDTH-1:0]);
          check_value("mem_write_data_keep", mem_write_data_keep, w[MEM_WIDTH +: MK]);
          check_value("mem_write_data_last", mem_write_data_last, w[MEM_WIDTH+MK]);
        end
      end
    end
  end

  initial begin
    wait (cycle_cnt >= MAX_CYCLES);
    errors++;
    $display("timeout after %0d cycles, streams did not drain (pending %0d %0d %0d %0d)",
             cycle_cnt, rd_cmd_q.size(), wr_cmd_q.size(), rd_dat_q.size(), wr_dat_q.size());
    finish_run();
  end

  initial begin
    net_aresetn          = 1'b0;
    eng_read_cmd_valid   = 1'b0;
    eng_read_cmd_data    = '0;
    mem_read_cmd_ready   = 1'b0;
    mem_read_data_valid  = 1'b0;
    mem_read_data_data   = '0;
    mem_read_data_keep   = '0;
    mem_read_data_last   = 1'b0;
    eng_read_data_ready  = 1'b0;
    eng_write_cmd_valid  = 1'b0;
    eng_write_cmd_data   = '0;
    mem_write_cmd_ready  = 1'b0;
    eng_write_data_valid = 1'b0;
    eng_write_data_data  = '0;
    eng_write_data_keep  = '0;
    eng_write_data_last  = 1'b0;
    mem_write_data_ready = 1'b0;
    rd_cmd_left   = N_CMD;
    wr_cmd_left   = N_CMD;
    rd_pkt_left   = N_PKT;
    wr_pkt_left   = N_PKT;
    rd_beats_left = 0;
    wr_beats_left = 0;
    repeat (4) begin                    // reset held 4 cycles
      @(negedge net_clk);
      check_idle();
    end
    net_aresetn = 1'b1;
    @(negedge net_clk);
    check_idle();                       // first cycle out of reset
    @(posedge net_clk);
    run = 1'b1;
    while (!all_done())
      @(negedge net_clk);
    repeat (3) @(negedge net_clk);      // counters settle
    check_value("read_cmd_count", read_cmd_count, activity_cnt_t'(rd_cmd_n));
    check_value("read_pkt_count", read_pkt_count, activity_cnt_t'(rd_pkt_n));
    check_value("write_cmd_count", write_cmd_count, activity_cnt_t'(wr_cmd_n));
    check_value("write_pkt_count", write_pkt_count, activity_cnt_t'(wr_pkt_n));
    check_value("outstanding_reads", outstanding_reads, activity_cnt_t'(rd_cmd_n - rd_pkt_n));
    finish_run();
  end

endmodule

/* tb.f */
verilog/tcp_mem_pkg.sv
verilog/axis_downsizer.sv
verilog/axis_upsizer.sv
verilog/mem_activity_counters.sv
verilog/tx_read_path.sv
verilog/tx_write_path.sv
verilog/tcp_mem_glue.sv
sim/tb_tcp_mem_glue.sv

/* verilog/axis_downsizer.sv */
/*
  splits one wide beat into narrow beats, low slice first
  stops after the highest slice with a keep bit set, so keep must not be all zero
  one wide beat buffered, next one may load while the final slice drains
*/
`timescale 1ns/1ps

module axis_downsizer #(
  parameter int NET_WIDTH = 64,
  parameter int MEM_WIDTH = 512
) (
  input  logic                   net_clk,
  input  logic                   net_aresetn,
  input  logic                   s_valid,
  output logic                   s_ready,
  input  logic [MEM_WIDTH-1:0]   s_data,
  input  logic [MEM_WIDTH/8-1:0] s_keep,
  input  logic                   s_last,
  output logic                   m_valid,
  input  logic                   m_ready,
  output logic [NET_WIDTH-1:0]   m_data,
  output logic [NET_WIDTH/8-1:0] m_keep,
  output logic                   m_last
);

  localparam int RATIO = MEM_WIDTH / NET_WIDTH;
  localparam int NK    = NET_WIDTH / 8;
  localparam int IDX_W = (RATIO > 1) ? $clog2(RATIO) : 1;

  logic [MEM_WIDTH-1:0]   buf_data;
  logic [MEM_WIDTH/8-1:0] buf_keep;
  logic                   buf_last;    // wide beat closed a packet
  logic                   buf_valid;
  logic [IDX_W-1:0]       idx;         // slice on offer
  logic [IDX_W-1:0]       last_idx;    // final slice of buffered beat
  logic [IDX_W-1:0]       in_last_idx;
  logic                   final_xfer;

  // highest slice with any keep bit set
  always_comb begin
    in_last_idx = '0;
    for (int i = 0; i < RATIO; i++) begin
      if (|s_keep[i*NK +: NK]) in_last_idx = IDX_W'(i);
    end
  end

  assign final_xfer = buf_valid && m_ready && (idx == last_idx);
  assign s_ready    = !buf_valid || final_xfer;   // reload in drain cycle

  assign m_valid = buf_valid;
  assign m_data  = buf_data[idx*NET_WIDTH +: NET_WIDTH];
  assign m_keep  = buf_keep[idx*NK +: NK];
  assign m_last  = buf_last && (idx == last_idx);

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      buf_valid <= 1'b0;
      idx       <= '0;
    end else if (s_valid && s_ready) begin
      buf_valid <= 1'b1;
      idx       <= '0;                            // restart at low slice
    end else if (final_xfer) begin
      buf_valid <= 1'b0;
    end else if (buf_valid && m_ready) begin
      idx       <= idx + 1'b1;
    end
  end

  always_ff @(posedge net_clk) begin
    if (s_valid && s_ready) begin
      buf_data <= s_data;
      buf_keep <= s_keep;
      buf_last <= s_last;
      last_idx <= in_last_idx;
    end
  end

  a_keep_nonzero: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    (s_valid && s_ready) |-> (|s_keep));

  a_data_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    (m_valid && !m_ready) |=> $stable(m_data));

endmodule

/* verilog/axis_upsizer.sv */
/*
  packs narrow beats into one wide beat, low slice first
  flushes when all slices are filled or on last, unfilled slices carry zero keep and data
  the wide beat appears the cycle after its final narrow beat
*/
`timescale 1ns/1ps

module axis_upsizer #(
  parameter int NET_WIDTH = 64,
  parameter int MEM_WIDTH = 512
) (
  input  logic                   net_clk,
  input  logic                   net_aresetn,
  input  logic                   s_valid,
  output logic                   s_ready,
  input  logic [NET_WIDTH-1:0]   s_data,
  input  logic [NET_WIDTH/8-1:0] s_keep,
  input  logic                   s_last,
  output logic                   m_valid,
  input  logic                   m_ready,
  output logic [MEM_WIDTH-1:0]   m_data,
  output logic [MEM_WIDTH/8-1:0] m_keep,
  output logic                   m_last
);

  localparam int RATIO = MEM_WIDTH / NET_WIDTH;
  localparam int NK    = NET_WIDTH / 8;
  localparam int IDX_W = (RATIO > 1) ? $clog2(RATIO) : 1;

  logic [MEM_WIDTH-1:0]   acc_data;
  logic [MEM_WIDTH/8-1:0] acc_keep;
  logic                   acc_last;
  logic [MEM_WIDTH-1:0]   nxt_data;
  logic [MEM_WIDTH/8-1:0] nxt_keep;
  logic                   out_valid;   // full wide beat on offer
  logic [IDX_W-1:0]       fill;        // next slice to write
  logic                   s_fire;
  logic                   flush;

  assign s_ready = !out_valid || m_ready;          // stall while full beat waits
  assign s_fire  = s_valid && s_ready;
  assign flush   = s_last || (fill == IDX_W'(RATIO - 1));

  // slice 0 starts a fresh beat, older slices cleared
  always_comb begin
    nxt_data = (fill == '0) ? '0 : acc_data;
    nxt_keep = (fill == '0) ? '0 : acc_keep;
    nxt_data[fill*NET_WIDTH +: NET_WIDTH] = s_data;
    nxt_keep[fill*NK +: NK]               = s_keep;
  end

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      out_valid <= 1'b0;
      fill      <= '0;
    end else begin
      if (out_valid && m_ready) out_valid <= 1'b0;
      if (s_fire) begin
        fill <= flush ? '0 : fill + 1'b1;
        if (flush) out_valid <= 1'b1;              // overrides drain in same cycle
      end
    end
  end

  always_ff @(posedge net_clk) begin
    if (s_fire) begin
      acc_data <= nxt_data;
      acc_keep <= nxt_keep;
      acc_last <= s_last;
    end
  end

  assign m_valid = out_valid;
  assign m_data  = acc_data;
  assign m_keep  = acc_keep;
  assign m_last  = acc_last;

  a_valid_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    (m_valid && !m_ready) |=> m_valid);

endmodule

/* verilog/mem_activity_counters.sv */
/*
  live traffic monitor for the tx buffer channel
  all counts wrap at 16 bits and update one cycle after the event pulse
  outstanding_reads is read commands minus read packets, modulo 2^16
*/
`timescale 1ns/1ps

module mem_activity_counters (
  input  logic                        net_clk,
  input  logic                        net_aresetn,
  input  logic                        read_cmd_fire,
  input  logic                        read_pkt_done,
  input  logic                        write_cmd_fire,
  input  logic                        write_pkt_done,
  output tcp_mem_pkg::activity_cnt_t  read_cmd_count,
  output tcp_mem_pkg::activity_cnt_t  read_pkt_count,
  output tcp_mem_pkg::activity_cnt_t  write_cmd_count,
  output tcp_mem_pkg::activity_cnt_t  write_pkt_count,
  output tcp_mem_pkg::activity_cnt_t  outstanding_reads
);

  import tcp_mem_pkg::*;

  activity_cnt_t outstanding_nxt;

  // cmd and pkt may land in one cycle, net change zero
  assign outstanding_nxt = outstanding_reads + activity_cnt_t'(read_cmd_fire)
                           - activity_cnt_t'(read_pkt_done);

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      read_cmd_count    <= '0;
      read_pkt_count    <= '0;
      write_cmd_count   <= '0;
      write_pkt_count   <= '0;
      outstanding_reads <= '0;
    end else begin
      if (read_cmd_fire)  read_cmd_count  <= read_cmd_count + 1'b1;
      if (read_pkt_done)  read_pkt_count  <= read_pkt_count + 1'b1;
      if (write_cmd_fire) write_cmd_count <= write_cmd_count + 1'b1;
      if (write_pkt_done) write_pkt_count <= write_pkt_count + 1'b1;
      outstanding_reads <= outstanding_nxt;     // tracks cmd minus pkt
    end
  end

endmodule

/* verilog/tcp_mem_glue.sv */
/*
  memory-side glue for one tx buffer channel of the tcp offload engine
  MEM_WIDTH must be a whole multiple of NET_WIDTH, keep widths are width/8
  commands pass with zero latency, data paths add one register stage
*/
`timescale 1ns/1ps

module tcp_mem_glue #(
  parameter int NET_WIDTH = 64,
  parameter int MEM_WIDTH = 512
) (
  input  logic                         net_clk,
  input  logic                         net_aresetn,
  // read commands
  input  logic                         eng_read_cmd_valid,
  output logic                         eng_read_cmd_ready,
  input  tcp_mem_pkg::hls_mem_cmd_t    eng_read_cmd_data,
  output logic                         mem_read_cmd_valid,
  input  logic                         mem_read_cmd_ready,
  output tcp_mem_pkg::mem_addr_t       mem_read_cmd_address,
  output tcp_mem_pkg::mem_len_t        mem_read_cmd_length,
  // read data, wide in and narrow out
  input  logic                         mem_read_data_valid,
  output logic                         mem_read_data_ready,
  input  logic [MEM_WIDTH-1:0]         mem_read_data_data,
  input  logic [MEM_WIDTH/8-1:0]       mem_read_data_keep,
  input  logic                         mem_read_data_last,
  output logic                         eng_read_data_valid,
  input  logic                         eng_read_data_ready,
  output logic [NET_WIDTH-1:0]         eng_read_data_data,
  output logic [NET_WIDTH/8-1:0]       eng_read_data_keep,
  output logic                         eng_read_data_last,
  // write commands
  input  logic                         eng_write_cmd_valid,
  output logic                         eng_write_cmd_ready,
  input  tcp_mem_pkg::hls_mem_cmd_t    eng_write_cmd_data,
  output logic                         mem_write_cmd_valid,
  input  logic                         mem_write_cmd_ready,
  output tcp_mem_pkg::mem_addr_t       mem_write_cmd_address,
  output tcp_mem_pkg::mem_len_t        mem_write_cmd_length,
  // write data, narrow in and wide out
  input  logic                         eng_write_data_valid,
  output logic                         eng_write_data_ready,
  input  logic [NET_WIDTH-1:0]         eng_write_data_data,
  input  logic [NET_WIDTH/8-1:0]       eng_write_data_keep,
  input  logic                         eng_write_data_last,
  output logic                         mem_write_data_valid,
  input  logic                         mem_write_data_ready,
  output logic [MEM_WIDTH-1:0]         mem_write_data_data,
  output logic [MEM_WIDTH/8-1:0]       mem_write_data_keep,
  output logic                         mem_write_data_last,
  // activity monitor
  output tcp_mem_pkg::activity_cnt_t   read_cmd_count,
  output tcp_mem_pkg::activity_cnt_t   read_pkt_count,
  output tcp_mem_pkg::activity_cnt_t   write_cmd_count,
  output tcp_mem_pkg::activity_cnt_t   write_pkt_count,
  output tcp_mem_pkg::activity_cnt_t   outstanding_reads
);

  logic read_cmd_fire;   // event pulses into the monitor
  logic read_pkt_done;
  logic write_cmd_fire;
  logic write_pkt_done;

  tx_read_path #(.NET_WIDTH(NET_WIDTH), .MEM_WIDTH(MEM_WIDTH)) i_read_path (
    .net_clk, .net_aresetn,
    .eng_read_cmd_valid, .eng_read_cmd_ready, .eng_read_cmd_data,
    .mem_read_cmd_valid, .mem_read_cmd_ready, .mem_read_cmd_address, .mem_read_cmd_length,
    .mem_read_data_valid, .mem_read_data_ready, .mem_read_data_data,
    .mem_read_data_keep, .mem_read_data_last,
    .eng_read_data_valid, .eng_read_data_ready, .eng_read_data_data,
    .eng_read_data_keep, .eng_read_data_last,
    .read_cmd_fire, .read_pkt_done
  );

  tx_write_path #(.NET_WIDTH(NET_WIDTH), .MEM_WIDTH(MEM_WIDTH)) i_write_path (
    .net_clk, .net_aresetn,
    .eng_write_cmd_valid, .eng_write_cmd_ready, .eng_write_cmd_data,
    .mem_write_cmd_valid, .mem_write_cmd_ready, .mem_write_cmd_address, .mem_write_cmd_length,
    .eng_write_data_valid, .eng_write_data_ready, .eng_write_data_data,
    .eng_write_data_keep, .eng_write_data_last,
    .mem_write_data_valid, .mem_write_data_ready, .mem_write_data_data,
    .mem_write_data_keep, .mem_write_data_last,
    .write_cmd_fire, .write_pkt_done
  );

  mem_activity_counters i_counters (
    .net_clk, .net_aresetn,
    .read_cmd_fire, .read_pkt_done, .write_cmd_fire, .write_pkt_done,
    .read_cmd_count, .read_pkt_count, .write_cmd_count, .write_pkt_count,
    .outstanding_reads
  );

endmodule

/* verilog/tcp_mem_pkg.sv */
/*
  shared types for the tcp offload memory glue
  engine buffer commands are 72 bits, only addr [63:32] and len [22:0] are used
  activity counters wrap at 16 bits
*/
package tcp_mem_pkg;

  typedef logic [71:0] hls_mem_cmd_t;   // packed engine buffer command
  typedef logic [63:0] mem_addr_t;      // byte address toward memory
  typedef logic [31:0] mem_len_t;       // transfer length in bytes
  typedef logic [15:0] activity_cnt_t;  // wrapping event count

  // address field, zero-extended to 64 bits
  function automatic mem_addr_t cmd_address(input hls_mem_cmd_t cmd);
    return {32'h0000_0000, cmd[63:32]};
  endfunction

  // length field, zero-extended to 32 bits
  function automatic mem_len_t cmd_length(input hls_mem_cmd_t cmd);
    return {9'h000, cmd[22:0]};
  endfunction

endpackage

/* verilog/tx_read_path.sv */
/*
  tx read channel: command repacking and 512 to 64 bit data narrowing
  the command stream is combinational, ready flows straight back
  event pulses are single cycle and unregistered
*/
`timescale 1ns/1ps

module tx_read_path #(
  parameter int NET_WIDTH = 64,
  parameter int MEM_WIDTH = 512
) (
  input  logic                         net_clk,
  input  logic                         net_aresetn,
  input  logic                         eng_read_cmd_valid,
  output logic                         eng_read_cmd_ready,
  input  tcp_mem_pkg::hls_mem_cmd_t    eng_read_cmd_data,
  output logic                         mem_read_cmd_valid,
  input  logic                         mem_read_cmd_ready,
  output tcp_mem_pkg::mem_addr_t       mem_read_cmd_address,
  output tcp_mem_pkg::mem_len_t        mem_read_cmd_length,
  input  logic                         mem_read_data_valid,
  output logic                         mem_read_data_ready,
  input  logic [MEM_WIDTH-1:0]         mem_read_data_data,
  input  logic [MEM_WIDTH/8-1:0]       mem_read_data_keep,
  input  logic                         mem_read_data_last,
  output logic                         eng_read_data_valid,
  input  logic                         eng_read_data_ready,
  output logic [NET_WIDTH-1:0]         eng_read_data_data,
  output logic [NET_WIDTH/8-1:0]       eng_read_data_keep,
  output logic                         eng_read_data_last,
  output logic                         read_cmd_fire,
  output logic                         read_pkt_done
);

  import tcp_mem_pkg::*;

  assign mem_read_cmd_valid   = eng_read_cmd_valid;
  assign eng_read_cmd_ready   = mem_read_cmd_ready;               // no buffering on commands
  assign mem_read_cmd_address = cmd_address(eng_read_cmd_data);
  assign mem_read_cmd_length  = cmd_length(eng_read_cmd_data);

  assign read_cmd_fire = mem_read_cmd_valid && mem_read_cmd_ready;
  assign read_pkt_done = mem_read_data_valid && mem_read_data_ready && mem_read_data_last; // wide side

  axis_downsizer #(.NET_WIDTH(NET_WIDTH), .MEM_WIDTH(MEM_WIDTH)) i_downsizer (
    .net_clk, .net_aresetn,
    .s_valid(mem_read_data_valid), .s_ready(mem_read_data_ready),
    .s_data(mem_read_data_data), .s_keep(mem_read_data_keep), .s_last(mem_read_data_last),
    .m_valid(eng_read_data_valid), .m_ready(eng_read_data_ready),
    .m_data(eng_read_data_data), .m_keep(eng_read_data_keep), .m_last(eng_read_data_last)
  );

  // engine must never request an empty buffer read
  a_read_len_nonzero: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    read_cmd_fire |-> (mem_read_cmd_length != '0));

endmodule

/* verilog/tx_write_path.sv */
/*
  tx write channel: command repacking and 64 to 512 bit data widening
  a packet end flushes a partly filled wide beat, unfilled slices are zero
*/
`timescale 1ns/1ps

module tx_write_path #(
  parameter int NET_WIDTH = 64,
  parameter int MEM_WIDTH = 512
) (
  input  logic                         net_clk,
  input  logic                         net_aresetn,
  input  logic                         eng_write_cmd_valid,
  output logic                         eng_write_cmd_ready,
  input  tcp_mem_pkg::hls_mem_cmd_t    eng_write_cmd_data,
  output logic                         mem_write_cmd_valid,
  input  logic                         mem_write_cmd_ready,
  output tcp_mem_pkg::mem_addr_t       mem_write_cmd_address,
  output tcp_mem_pkg::mem_len_t        mem_write_cmd_length,
  input  logic                         eng_write_data_valid,
  output logic                         eng_write_data_ready,
  input  logic [NET_WIDTH-1:0]         eng_write_data_data,
  input  logic [NET_WIDTH/8-1:0]       eng_write_data_keep,
  input  logic                         eng_write_data_last,
  output logic                         mem_write_data_valid,
  input  logic                         mem_write_data_ready,
  output logic [MEM_WIDTH-1:0]         mem_write_data_data,
  output logic [MEM_WIDTH/8-1:0]       mem_write_data_keep,
  output logic                         mem_write_data_last,
  output logic                         write_cmd_fire,
  output logic                         write_pkt_done
);

  import tcp_mem_pkg::*;

  assign mem_write_cmd_valid   = eng_write_cmd_valid;
  assign eng_write_cmd_ready   = mem_write_cmd_ready;
  assign mem_write_cmd_address = cmd_address(eng_write_cmd_data);
  assign mem_write_cmd_length  = cmd_length(eng_write_cmd_data);

  assign write_cmd_fire = mem_write_cmd_valid && mem_write_cmd_ready;
  assign write_pkt_done = eng_write_data_valid && eng_write_data_ready && eng_write_data_last; // narrow side

  axis_upsizer #(.NET_WIDTH(NET_WIDTH), .MEM_WIDTH(MEM_WIDTH)) i_upsizer (
    .net_clk, .net_aresetn,
    .s_valid(eng_write_data_valid), .s_ready(eng_write_data_ready),
    .s_data(eng_write_data_data), .s_keep(eng_write_data_keep), .s_last(eng_write_data_last),
    .m_valid(mem_write_data_valid), .m_ready(mem_write_data_ready),
    .m_data(mem_write_data_data), .m_keep(mem_write_data_keep), .m_last(mem_write_data_last)
  );

endmodule
